//--- verification/readout_patterns.txt
// board0_offset board1_offset src_ip dst_ip first_packet_checksum
// one trigger per line, all values hex
0005 0123 c0a80001 c0a80064 b8fb
3ffe 1000 0a000005 0a0000c8 25cd
0000 2abc ac10fffe ffffffff 8e72

//--- sim.f
+incdir+source
source/readout_pkg.sv
source/readout_addr_gen.sv
source/sample_queue.sv
source/udp_header_gen.sv
source/udp_byte_framer.sv
source/readout_top.sv
verification/readout_chk.sv
verification/readout_tb.sv

//--- verification/readout_tb.sv
`default_nettype none

`include "readout_defs.svh"

module readout_tb import readout_pkg::*; ();

	localparam int TOTAL    = `READOUT_NUM_BOARDS * `READOUT_CHANNELS * `READOUT_STEPS;
	localparam int DEPTH    = `READOUT_QUEUE_DEPTH;
	localparam int NUM_TRIG = 3;
	localparam int PKT_LEN  = `IP_LEN;

	logic clk;
	logic rst_n;
	logic trigger;
	offset_t [`READOUT_NUM_BOARDS-1:0] board_offsets;
	ip_addr_t src_ip;
	ip_addr_t dst_ip;
	port_t src_port;
	port_t dst_port;
	logic dram_rd_en;
	dram_addr_t dram_rd_addr;
	sample_word_t dram_rd_data;
	logic dram_rd_valid;
	logic readout_busy;
	tx_byte_t tx_data;
	logic tx_valid;
	logic tx_last;

	logic [31:0] patterns [5*NUM_TRIG];   // five words per trigger
	logic [31:0] lfsr = 32'h8308_4342;
	offset_t cur_off [`READOUT_NUM_BOARDS];
	port_t pat_csum;
	dram_addr_t addr_q [$];      // dram model requests in flight
	int ready_q [$];
	tx_byte_t pkt [PKT_LEN];
	logic [15:0] ident = '0;
	int cyc = 0;
	int last_ready = 0;
	int lat_v;
	int req_idx = 0;
	int pkt_done = 0;
	int byte_idx = 0;
	int extra_lat = 0;
	logic armed = 1'b0;
	logic stall_seen = 1'b0;
	logic prev_valid = 1'b0;
	logic b_hi;
	logic b_lo;

	readout_top UUT (.*);

	always #50 clk = ~clk;

	task automatic wait_cycle();
		@(posedge clk);
		#1;
	endtask

	task automatic abort_run();
		$display("Test FAILED");
		$fatal(1, "stopped at first error");
	endtask

	task automatic report_failure(input string what);
		$display("ERROR: %s", what);
		abort_run();
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("MISMATCH %s got 0x%h expected 0x%h", name, got, exp);
			abort_run();
		end
	endtask

	task automatic check_byte(input string name, input tx_byte_t got, input tx_byte_t exp);
		if (got !== exp) begin
			$display("MISMATCH %s got 0x%h expected 0x%h", name, got, exp);
			abort_run();
		end
	endtask

	task automatic check_addr(input string name, input dram_addr_t got, input dram_addr_t exp);
		if (got !== exp) begin
			$display("MISMATCH %s got 0x%h expected 0x%h", name, got, exp);
			abort_run();
		end
	endtask

	task automatic check_checksum(input string name, input port_t got, input port_t exp);
		if (got !== exp) begin
			$display("MISMATCH %s got 0x%h expected 0x%h", name, got, exp);
			abort_run();
		end
	endtask

	//////////////////////////////
	// reference models

	function automatic logic draw_bit();
		lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
		return lfsr[0];
	endfunction

	function automatic sample_word_t make_word(input dram_addr_t a);
		sample_word_t w;
		for (int i = 0; i < 8; i++)
			w[32*i +: 32] = i[0] ? ~32'(a) : 32'(a);   // odd lanes inverted
		return w;
	endfunction

	function automatic dram_addr_t expected_addr(input int idx);
		int ch;
		int b;
		int step;
		offset_t off;
		ch   = idx % `READOUT_CHANNELS;
		b    = (idx / `READOUT_CHANNELS) % `READOUT_NUM_BOARDS;
		step = idx / (`READOUT_CHANNELS * `READOUT_NUM_BOARDS);
		off  = cur_off[b] + offset_t'(step);
		return dram_addr_t'({board_t'(b), channel_t'(ch), off});
	endfunction

	function automatic port_t ip_checksum(input logic [15:0] id, input ip_addr_t s,
		input ip_addr_t d);
		logic [31:0] sum;
		sum = 32'h4500 + 32'(`IP_LEN) + 32'(id) + 32'h4000 + 32'((`IP_TTL << 8) | 17)
			+ s[31:16] + s[15:0] + d[31:16] + d[15:0];
		while (sum[31:16] != '0)
			sum = sum[15:0] + sum[31:16];   // end-around carry
		return ~sum[15:0];
	endfunction

	task automatic verify_packet();
		logic [15:0] hw [14];
		port_t csum;
		sample_word_t w;
		csum = ip_checksum(ident, src_ip, dst_ip);
		check_checksum("ip checksum", {pkt[10], pkt[11]}, csum);
		if (pkt_done == 0)
			check_checksum("ip checksum vs pattern", {pkt[10], pkt[11]}, pat_csum);
		hw[0]  = 16'h4500;
		hw[1]  = 16'(`IP_LEN);
		hw[2]  = ident;
		hw[3]  = 16'h4000;                  // don't fragment
		hw[4]  = {8'(`IP_TTL), 8'd17};
		hw[5]  = csum;
		hw[6]  = src_ip[31:16];
		hw[7]  = src_ip[15:0];
		hw[8]  = dst_ip[31:16];
		hw[9]  = dst_ip[15:0];
		hw[10] = src_port;
		hw[11] = dst_port;
		hw[12] = 16'(`UDP_LEN);
		hw[13] = 16'h0000;
		for (int i = 0; i < 28; i++)
			check_byte($sformatf("tx_data header byte %0d", i), pkt[i],
				i[0] ? hw[i/2][7:0] : hw[i/2][15:8]);
		w = make_word(expected_addr(pkt_done));
		for (int j = 0; j < 32; j++)
			check_byte($sformatf("tx_data data byte %0d", j), pkt[28+j], w[255-8*j -: 8]);
	endtask

	//////////////////////////////
	// dram model answers in order after 1 to 4 cycles plus extra_lat
	always @(posedge clk) begin
		cyc++;
		#1;
		dram_rd_valid = 1'b0;
		if (ready_q.size() > 0 && ready_q[0] <= cyc) begin
			dram_rd_valid = 1'b1;
			dram_rd_data  = make_word(addr_q.pop_front());
			void'(ready_q.pop_front());
		end
	end

	// monitor samples mid cycle
	always @(negedge clk) begin
		if (rst_n) begin
			if (UUT.u_chk.fail_count != 0)
				report_failure("an assertion in the bound checker failed");
			if (dram_rd_en) begin
				if (!armed || req_idx >= TOTAL)
					report_failure("DRAM read request outside an accepted trigger");
				check_addr("dram_rd_addr", dram_rd_addr, expected_addr(req_idx));
				b_hi  = draw_bit();
				b_lo  = draw_bit();
				lat_v = cyc + 1 + 2 * b_hi + b_lo + extra_lat;
				if (lat_v <= last_ready)
					lat_v = last_ready + 1;
				last_ready = lat_v;
				addr_q.push_back(dram_rd_addr);
				ready_q.push_back(lat_v);
				req_idx++;
			end else if (readout_busy && req_idx > 0 && req_idx < TOTAL) begin
				stall_seen = 1'b1;          // out of credits
			end
			if (req_idx - pkt_done > DEPTH + 1)
				report_failure("more words outstanding than the queue credits allow");
			if (!tx_valid && byte_idx != 0)
				report_failure("tx_valid dropped inside a packet");
			if (tx_valid) begin
				if (byte_idx == 0) begin
					if (prev_valid)
						report_failure("packets sent with no idle cycle between them");
					if (!armed || pkt_done >= TOTAL)
						report_failure("packet sent with no trigger pending");
					check_flag("readout_busy", readout_busy, pkt_done < TOTAL - 1);
				end
				pkt[byte_idx] = tx_data;
				check_flag("tx_last", tx_last, byte_idx == PKT_LEN - 1);
				byte_idx++;
				if (byte_idx == PKT_LEN) begin
					verify_packet();
					byte_idx  = 0;
					pkt_done++;
					ident++;
					extra_lat = 0;
				end
			end
			prev_valid = tx_valid;
		end
	end

	task automatic run_trigger(input int t);
		int n;
		for (int b = 0; b < `READOUT_NUM_BOARDS; b++) begin
			cur_off[b]       = patterns[5*t+b][`READOUT_OFFSET_W-1:0];
			board_offsets[b] = cur_off[b];
		end
		src_ip     = patterns[5*t+2];
		dst_ip     = patterns[5*t+3];
		pat_csum   = patterns[5*t+4][15:0];
		req_idx    = 0;
		pkt_done   = 0;
		stall_seen = 1'b0;
		extra_lat  = 10;                    // slow dram for the first packet
		armed      = 1'b1;
		trigger    = 1'b1;
		wait_cycle();
		trigger = 1'b0;
		n = 0;
		while (!readout_busy) begin
			wait_cycle();
			n++;
			if (n > 4)
				report_failure("readout_busy did not rise after the trigger");
		end
		trigger = 1'b1;                     // must be ignored while busy
		wait_cycle();
		trigger = 1'b0;
		n = 0;
		while (req_idx < TOTAL) begin
			wait_cycle();
			n++;
			if (n > 3000)
				report_failure("timed out waiting for the DRAM read requests");
		end
		if (readout_busy) begin
			trigger = 1'b1;                 // generator idle but packets pending
			wait_cycle();
			trigger = 1'b0;
		end
		n = 0;
		while (pkt_done < TOTAL) begin
			wait_cycle();
			n++;
			if (n > 4000)
				report_failure("timed out waiting for the output packets");
		end
		if (!stall_seen)
			report_failure("request stream never stalled on queue credits");
		for (n = 0; n < 20; n++) begin
			wait_cycle();
			check_flag("readout_busy", readout_busy, 1'b0);
		end
	endtask

	initial begin
		clk           = 1'b0;
		rst_n         = 1'b0;
		trigger       = 1'b0;
		board_offsets = '0;
		src_ip        = '0;
		dst_ip        = '0;
		src_port      = 16'h1f90;
		dst_port      = 16'h2710;
		dram_rd_data  = '0;
		dram_rd_valid = 1'b0;
		$readmemh("verification/readout_patterns.txt", patterns);
		repeat (10) wait_cycle();
		rst_n = 1'b1;
		for (int i = 0; i < 5; i++) begin
			wait_cycle();
			check_flag("dram_rd_en", dram_rd_en, 1'b0);
			check_flag("tx_valid", tx_valid, 1'b0);
			check_flag("tx_last", tx_last, 1'b0);
			check_flag("readout_busy", readout_busy, 1'b0);
		end
		for (int t = 0; t < NUM_TRIG; t++)
			run_trigger(t);
		if (UUT.u_chk.fail_count != 0) begin
			report_failure("the bound checker reported assertion failures");
		end else begin
			$display("Test OK");
			$finish;
		end
	end

endmodule

`default_nettype wire

//--- verification/readout_chk.sv
`default_nettype none

`include "readout_defs.svh"

module readout_chk import readout_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       push,
	input  queue_cnt_t fill,
	input  logic       dram_rd_en,
	input  logic       readout_busy,
	input  logic       tx_valid,
	input  logic       tx_last
);

	int fail_count = 0;   // failed assertions so far

	// credits must keep the queue from overflowing
	assert property (@(posedge clk) disable iff (!rst_n)
		push |-> fill < queue_cnt_t'(`READOUT_QUEUE_DEPTH))
		else begin
			fail_count++;
			$error("sample queue pushed while full");
		end

	assert property (@(posedge clk) disable iff (!rst_n) tx_last |-> tx_valid)
		else begin
			fail_count++;
			$error("tx_last high without tx_valid");
		end

	assert property (@(posedge clk) disable iff (!rst_n) dram_rd_en |-> readout_busy)
		else begin
			fail_count++;
			$error("dram read request while readout is not busy");
		end

endmodule

bind readout_top readout_chk u_chk (
	.clk          (clk),
	.rst_n        (rst_n),
	.push         (dram_rd_valid),
	.fill         (q_fill),
	.dram_rd_en   (dram_rd_en),
	.readout_busy (readout_busy),
	.tx_valid     (tx_valid),
	.tx_last      (tx_last)
);

`default_nettype wire

//--- source/readout_top.sv
`default_nettype none

`include "readout_defs.svh"

module readout_top import readout_pkg::*; (
	input  logic                              clk,
	input  logic                              rst_n,
	input  logic                              trigger,
	input  offset_t [`READOUT_NUM_BOARDS-1:0] board_offsets,
	input  ip_addr_t                          src_ip,
	input  ip_addr_t                          dst_ip,
	input  port_t                             src_port,
	input  port_t                             dst_port,
	output logic                              dram_rd_en,
	output dram_addr_t                        dram_rd_addr,
	input  sample_word_t                      dram_rd_data,
	input  logic                              dram_rd_valid,
	output logic                              readout_busy,
	output tx_byte_t                          tx_data,
	output logic                              tx_valid,
	output logic                              tx_last
);

	logic         word_pop;
	logic         frame_start;
	logic         word_avail;
	sample_word_t q_word;
	queue_cnt_t   q_fill;       // watched by the checker
	header_t      header;

	readout_addr_gen u_addr_gen (
		.clk           (clk),
		.rst_n         (rst_n),
		.trigger       (trigger),
		.board_offsets (board_offsets),
		.credit_return (word_pop),
		.dram_rd_en    (dram_rd_en),
		.dram_rd_addr  (dram_rd_addr),
		.readout_busy  (readout_busy)
	);

	sample_queue u_queue (
		.clk        (clk),
		.rst_n      (rst_n),
		.push       (dram_rd_valid),
		.in_word    (dram_rd_data),
		.pop        (word_pop),
		.out_word   (q_word),
		.word_avail (word_avail),
		.fill       (q_fill)
	);

	udp_header_gen u_header (
		.clk         (clk),
		.rst_n       (rst_n),
		.frame_start (frame_start),
		.src_ip      (src_ip),
		.dst_ip      (dst_ip),
		.src_port    (src_port),
		.dst_port    (dst_port),
		.header      (header)
	);

	udp_byte_framer u_framer (
		.clk         (clk),
		.rst_n       (rst_n),
		.word_avail  (word_avail),
		.word_pop    (word_pop),
		.frame_start (frame_start),
		.word        (q_word),
		.header      (header),
		.tx_data     (tx_data),
		.tx_valid    (tx_valid),
		.tx_last     (tx_last)
	);

endmodule

`default_nettype wire

//--- source/udp_byte_framer.sv
`default_nettype none

`include "readout_defs.svh"

module udp_byte_framer import readout_pkg::*; (
	input  logic         clk,
	input  logic         rst_n,
	input  logic         word_avail,
	output logic         word_pop,
	output logic         frame_start,
	input  sample_word_t word,
	input  header_t      header,
	output tx_byte_t     tx_data,
	output logic         tx_valid,
	output logic         tx_last
);

	localparam int HDR_BYTES = $bits(header_t) / 8;
	localparam int PKT_BYTES = `IP_LEN;

	frame_state_t state;
	logic [5:0]   byte_cnt;     // bytes already sent in this packet
	header_t      hdr_sr;
	sample_word_t data_sr;

	assign word_pop    = (state == FRAME_IDLE) && word_avail;
	assign frame_start = word_pop;

	//////////////////////////////
	// packet FSM
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state    <= FRAME_IDLE;
			byte_cnt <= '0;
			tx_valid <= 1'b0;
			tx_last  <= 1'b0;
		end else begin
			case (state)
				FRAME_IDLE: begin
					tx_valid <= 1'b0;
					tx_last  <= 1'b0;
					if (word_pop) begin
						state    <= FRAME_HEADER;
						byte_cnt <= '0;
					end
				end
				FRAME_HEADER: begin
					tx_valid <= 1'b1;
					byte_cnt <= byte_cnt + 1'b1;
					if (byte_cnt == 6'(HDR_BYTES - 1))
						state <= FRAME_DATA;
				end
				FRAME_DATA: begin
					byte_cnt <= byte_cnt + 1'b1;
					if (byte_cnt == 6'(PKT_BYTES - 1)) begin
						tx_last <= 1'b1;
						state   <= FRAME_IDLE;
					end
				end
				default: state <= FRAME_IDLE;
			endcase
		end
	end

	// byte shifters, msb first
	always_ff @(posedge clk) begin
		case (state)
			FRAME_HEADER: begin
				if (byte_cnt == '0) begin
					tx_data <= header[$bits(header_t)-1 -: 8];   // queue word and header now valid
					hdr_sr  <= header << 8;
					data_sr <= word;
				end else begin
					tx_data <= hdr_sr[$bits(header_t)-1 -: 8];
					hdr_sr  <= hdr_sr << 8;
				end
			end
			FRAME_DATA: begin
				tx_data <= data_sr[$bits(sample_word_t)-1 -: 8];
				data_sr <= data_sr << 8;
			end
			default: tx_data <= tx_data;
		endcase
	end

endmodule

`default_nettype wire

//--- source/udp_header_gen.sv
`default_nettype none

`include "readout_defs.svh"

module udp_header_gen import readout_pkg::*; (
	input  logic     clk,
	input  logic     rst_n,
	input  logic     frame_start,
	input  ip_addr_t src_ip,
	input  ip_addr_t dst_ip,
	input  port_t    src_port,
	input  port_t    dst_port,
	output header_t  header
);

	localparam logic [15:0] VER_IHL_TOS = 16'h4500;  // ipv4, 5 words, dscp/ecn 0
	localparam logic [15:0] FLAGS_FRAG  = 16'h4000;  // don't fragment, offset 0
	localparam logic [7:0]  IP_PROTO    = 8'd17;     // udp

	logic [15:0] ident;
	logic [19:0] sum;
	logic [16:0] fold;
	logic [15:0] csum;

	// ones' complement sum over the ten header words, checksum word as zero
	always_comb begin
		sum = 20'(VER_IHL_TOS) + 20'(16'(`IP_LEN)) + 20'(ident) + 20'(FLAGS_FRAG)
			+ 20'({8'(`IP_TTL), IP_PROTO})
			+ 20'(src_ip[31:16]) + 20'(src_ip[15:0])
			+ 20'(dst_ip[31:16]) + 20'(dst_ip[15:0]);
		fold = 17'(sum[15:0]) + 17'(sum[19:16]);
		csum = ~(fold[15:0] + 16'(fold[16]));   // second fold catches the carry
	end

	always_ff @(posedge clk) begin
		if (!rst_n)
			ident <= '0;
		else if (frame_start)
			ident <= ident + 1'b1;
	end

	always_ff @(posedge clk) begin
		if (frame_start)
			header <= {VER_IHL_TOS, 16'(`IP_LEN), ident, FLAGS_FRAG,
				8'(`IP_TTL), IP_PROTO, csum, src_ip, dst_ip,
				src_port, dst_port, 16'(`UDP_LEN), 16'h0000};   // udp checksum unused
	end

endmodule

`default_nettype wire

//--- source/sample_queue.sv
`default_nettype none

`include "readout_defs.svh"

module sample_queue import readout_pkg::*; (
	input  logic         clk,
	input  logic         rst_n,
	input  logic         push,
	input  sample_word_t in_word,
	input  logic         pop,
	output sample_word_t out_word,
	output logic         word_avail,
	output queue_cnt_t   fill
);

	localparam int DEPTH = `READOUT_QUEUE_DEPTH;
	localparam int PTR_W = $clog2(DEPTH);

	sample_word_t     mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;

	assign word_avail = fill != '0;

	// storage and registered read port
	always_ff @(posedge clk) begin
		if (push)
			mem[wr_ptr] <= in_word;
		if (pop)
			out_word <= mem[rd_ptr];      // valid the cycle after pop
	end

	//////////////////////////////
	// pointers and fill level
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			fill   <= '0;
		end else begin
			if (push)
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			case ({push, pop})
				2'b10:   fill <= fill + 1'b1;
				2'b01:   fill <= fill - 1'b1;
				default: fill <= fill;   // idle or push and pop together
			endcase
		end
	end

endmodule

`default_nettype wire

//--- source/readout_addr_gen.sv
`default_nettype none

`include "readout_defs.svh"

module readout_addr_gen import readout_pkg::*; (
	input  logic                              clk,
	input  logic                              rst_n,
	input  logic                              trigger,
	input  offset_t [`READOUT_NUM_BOARDS-1:0] board_offsets,
	input  logic                              credit_return,
	output logic                              dram_rd_en,
	output dram_addr_t                        dram_rd_addr,
	output logic                              readout_busy
);

	localparam int TOTAL = `READOUT_NUM_BOARDS * `READOUT_CHANNELS * `READOUT_STEPS;
	localparam int CNT_W = $clog2(TOTAL + 1);
	localparam int PAD_W = $bits(dram_addr_t) - $bits(board_t) - $bits(channel_t)
		- $bits(offset_t);

	gen_state_t       state;
	board_t           board_sel;
	channel_t         chan_sel;
	offset_t          lat_offset [`READOUT_NUM_BOARDS];
	logic [CNT_W-1:0] req_cnt;      // requests issued this trigger
	logic [CNT_W-1:0] pending;      // words not yet popped by the framer
	queue_cnt_t       credits;
	logic             start;
	logic             chan_last;
	logic             board_last;

	assign start      = (state == GEN_IDLE) && trigger && !readout_busy;
	assign chan_last  = chan_sel == channel_t'(`READOUT_CHANNELS - 1);
	assign board_last = board_sel == board_t'(`READOUT_NUM_BOARDS - 1);

	// one request per cycle while the queue has room for the answer
	assign dram_rd_en   = (state == GEN_READING) && (credits != '0);
	assign dram_rd_addr = {{PAD_W{1'b0}}, board_sel, chan_sel, lat_offset[board_sel]};

	//////////////////////////////
	// sequencing: channel fastest, then board, then step
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state     <= GEN_IDLE;
			board_sel <= '0;
			chan_sel  <= '0;
			req_cnt   <= '0;
		end else if (start) begin
			state     <= GEN_READING;
			board_sel <= '0;
			chan_sel  <= '0;
			req_cnt   <= '0;
		end else if (dram_rd_en) begin
			req_cnt  <= req_cnt + 1'b1;
			chan_sel <= chan_last ? '0 : chan_sel + 1'b1;
			if (chan_last)
				board_sel <= board_last ? '0 : board_sel + 1'b1;
			if (req_cnt == CNT_W'(TOTAL - 1))
				state <= GEN_IDLE;          // last request issued
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			for (int b = 0; b < `READOUT_NUM_BOARDS; b++)
				lat_offset[b] <= board_offsets[b] - offset_t'(`READOUT_HEAD_DIFF);
		end else if (dram_rd_en && chan_last && board_last) begin
			for (int b = 0; b < `READOUT_NUM_BOARDS; b++)
				lat_offset[b] <= lat_offset[b] + 1'b1;   // next sample step
		end
	end

	//////////////////////////////
	// flow control and busy tracking
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			credits      <= queue_cnt_t'(`READOUT_QUEUE_DEPTH);
			pending      <= '0;
			readout_busy <= 1'b0;
		end else begin
			case ({dram_rd_en, credit_return})
				2'b10:   credits <= credits - 1'b1;
				2'b01:   credits <= credits + 1'b1;
				default: credits <= credits;
			endcase
			if (start) begin
				pending      <= CNT_W'(TOTAL);
				readout_busy <= 1'b1;
			end else if (credit_return) begin
				pending <= pending - 1'b1;
				if (pending == CNT_W'(1))
					readout_busy <= 1'b0;   // final word handed to the framer
			end
		end
	end

endmodule

`default_nettype wire

//--- source/readout_pkg.sv
`default_nettype none

`include "readout_defs.svh"

package readout_pkg;

	typedef logic [`READOUT_OFFSET_W-1:0] offset_t;
	typedef logic [0:0]                   board_t;
	typedef logic [1:0]                   channel_t;
	typedef logic [24:0]                  dram_addr_t;    // pad, board, channel, offset
	typedef logic [255:0]                 sample_word_t;
	typedef logic [223:0]                 header_t;       // 20 byte ip + 8 byte udp
	typedef logic [31:0]                  ip_addr_t;
	typedef logic [15:0]                  port_t;
	typedef logic [7:0]                   tx_byte_t;
	typedef logic [3:0]                   queue_cnt_t;

	typedef enum logic {
		GEN_IDLE,
		GEN_READING
	} gen_state_t;

	typedef enum logic [1:0] {
		FRAME_IDLE,
		FRAME_HEADER,
		FRAME_DATA
	} frame_state_t;

endpackage

`default_nettype wire

//--- source/readout_defs.svh
`ifndef READOUT_DEFS_SVH
`define READOUT_DEFS_SVH

// readout geometry
`define READOUT_NUM_BOARDS  2
`define READOUT_CHANNELS    4
`define READOUT_STEPS       3        // samples per channel per trigger
`define READOUT_OFFSET_W    14
`define READOUT_HEAD_DIFF   0        // pulled off every board offset at trigger
`define READOUT_QUEUE_DEPTH 8

// fixed IPv4/UDP header fields
`define IP_TTL  64
`define IP_LEN  60                   // 20 ip + 8 udp + 32 data
`define UDP_LEN 40                   // 8 udp + 32 data

`endif
